// ==== core_mem.f ====
hw/core_mem_pkg.sv
hw/mem_arbiter.sv
hw/axi_lite_manager.sv
hw/axi_lite_sram.sv
hw/core_mem_top.sv
verif/core_mem_tb.sv

// ==== hw/axi_lite_manager.sv ====
////////////////////////////////////////////////////////////
// AXI4-Lite manager for single-word and sub-word accesses
// Mealy FSM over the AW, W, B, AR and R channels,
// strobe generation, write-data replication, read lane pick
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axi_lite_manager (
    input  logic                                            i_clk,
    input  logic                                            i_rst_n,
    // Selected request from the arbiter
    input  logic                                            sel_valid,
    input  logic                                            sel_wen,
    input  core_mem_pkg::size_e                             sel_size,
    input  core_mem_pkg::paddr_t                            sel_addr,
    input  core_mem_pkg::word_t                             sel_wdata,
    output logic                                            sel_ready,
    output core_mem_pkg::word_t                             sel_rdata,
    // Write address channel
    output logic                                            awvalid,
    input  logic                                            awready,
    output core_mem_pkg::paddr_t                            awaddr,
    output logic [2:0]                                      awprot,
    // Write data channel
    output logic                                            wvalid,
    input  logic                                            wready,
    output core_mem_pkg::word_t                             wdata,
    output logic [core_mem_pkg::STRB_WIDTH-1:0]             wstrb,
    // Write response channel, response code not checked
    input  logic                                            bvalid,
    output logic                                            bready,
    input  logic [1:0]                                      bresp,
    // Read address channel
    output logic                                            arvalid,
    input  logic                                            arready,
    output core_mem_pkg::paddr_t                            araddr,
    output logic [2:0]                                      arprot,
    // Read data channel
    input  logic                                            rvalid,
    output logic                                            rready,
    input  core_mem_pkg::word_t                             rdata,
    input  logic [1:0]                                      rresp
);
    import core_mem_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        SEND_RADDR,     // AR not yet accepted
        GET_RDATA,      // Waiting on R
        SEND_WADDR,     // W accepted, AW still pending
        SEND_WDATA,     // AW accepted, W still pending
        GET_BRESP       // Waiting on B
    } state_e;

    state_e state;
    state_e next_state;

    logic aw_done;
    logic w_done;
    logic b_done;
    logic ar_done;
    logic r_done;
    logic start_wr;     // Write issued straight from IDLE
    logic start_rd;

    assign aw_done = awvalid && awready;
    assign w_done  = wvalid && wready;
    assign b_done  = bvalid && bready;
    assign ar_done = arvalid && arready;
    assign r_done  = rvalid && rready;

    assign start_wr = (state == IDLE) && sel_valid && sel_wen;
    assign start_rd = (state == IDLE) && sel_valid && !sel_wen;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start_wr) begin
                    if (aw_done && w_done) begin
                        next_state = GET_BRESP;
                    end else if (aw_done) begin
                        next_state = SEND_WDATA;
                    end else if (w_done) begin
                        next_state = SEND_WADDR;
                    end
                    // Neither accepted, IDLE keeps both valids up
                end else if (start_rd) begin
                    next_state = ar_done ? GET_RDATA : SEND_RADDR;
                end
            end
            SEND_RADDR: if (ar_done) next_state = GET_RDATA;
            GET_RDATA:  if (r_done)  next_state = IDLE;
            SEND_WADDR: if (aw_done) next_state = GET_BRESP;
            SEND_WDATA: if (w_done)  next_state = GET_BRESP;
            GET_BRESP:  if (b_done)  next_state = IDLE;
            default:    next_state = IDLE;
        endcase
    end

    // Channel valids, held by the state until each handshake
    assign awvalid = start_wr || (state == SEND_WADDR);
    assign wvalid  = start_wr || (state == SEND_WDATA);
    assign arvalid = start_rd || (state == SEND_RADDR);
    assign rready  = (state == GET_RDATA);
    assign bready  = 1'b1;   // B is always consumed on arrival

    // One-cycle completion on the response handshake
    assign sel_ready = ((state == GET_RDATA) && r_done) || ((state == GET_BRESP) && b_done);

    // Word-aligned addresses, lanes chosen by strobe and mux
    assign awaddr = {sel_addr[PADDR_WIDTH-1:2], 2'b00};
    assign araddr = {sel_addr[PADDR_WIDTH-1:2], 2'b00};
    assign awprot = 3'b000;  // Unprivileged, secure, data
    assign arprot = 3'b000;

    // Strobe and replicated write data
    always_comb begin
        case (sel_size)
            SIZE_BYTE: begin
                wstrb = STRB_WIDTH'(1) << sel_addr[1:0];   // One-hot lane
                wdata = {4{sel_wdata[7:0]}};
            end
            SIZE_HALFWORD: begin
                wstrb = sel_addr[1] ? 4'b1100 : 4'b0011;
                wdata = {2{sel_wdata[15:0]}};
            end
            default: begin
                wstrb = 4'b1111;
                wdata = sel_wdata;
            end
        endcase
    end

    // Lane extraction with zero extension
    always_comb begin
        case (sel_size)
            SIZE_BYTE: begin
                case (sel_addr[1:0])
                    2'b00:   sel_rdata = {24'h0, rdata[7:0]};
                    2'b01:   sel_rdata = {24'h0, rdata[15:8]};
                    2'b10:   sel_rdata = {24'h0, rdata[23:16]};
                    default: sel_rdata = {24'h0, rdata[31:24]};
                endcase
            end
            SIZE_HALFWORD: sel_rdata = sel_addr[1] ? {16'h0, rdata[31:16]}
                                                   : {16'h0, rdata[15:0]};
            default:       sel_rdata = rdata;
        endcase
    end

endmodule : axi_lite_manager

// ==== hw/axi_lite_sram.sv ====
////////////////////////////////////////////////////////////
// AXI4-Lite subordinate word memory
// Byte-strobed writes, registered reads,
// responses one cycle after acceptance
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axi_lite_sram (
    input  logic                                    i_clk,
    input  logic                                    i_rst_n,
    // Write address and data, accepted together
    input  logic                                    awvalid,
    output logic                                    awready,
    input  core_mem_pkg::paddr_t                    awaddr,
    input  logic                                    wvalid,
    output logic                                    wready,
    input  core_mem_pkg::word_t                     wdata,
    input  logic [core_mem_pkg::STRB_WIDTH-1:0]     wstrb,
    // Write response
    output logic                                    bvalid,
    input  logic                                    bready,
    output logic [1:0]                              bresp,
    // Read address and data
    input  logic                                    arvalid,
    output logic                                    arready,
    input  core_mem_pkg::paddr_t                    araddr,
    output logic                                    rvalid,
    input  logic                                    rready,
    output core_mem_pkg::word_t                     rdata,
    output logic [1:0]                              rresp
);
    import core_mem_pkg::*;

    word_t mem [MEM_WORDS];

    logic                 wr_accept;
    logic                 rd_accept;
    logic [MEM_IDX_W-1:0] wr_idx;
    logic [MEM_IDX_W-1:0] rd_idx;

    // AW and W taken as a pair, blocked while B is outstanding
    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awready;
    assign arready = !rvalid;  // One read in flight at most

    assign wr_accept = awvalid && awready;
    assign rd_accept = arvalid && arready;

    // Higher address bits wrap onto the same words
    assign wr_idx = awaddr[MEM_IDX_W+1:2];
    assign rd_idx = araddr[MEM_IDX_W+1:2];

    assign bresp = 2'b00;      // Always OKAY
    assign rresp = 2'b00;

    // Storage and read data
    always_ff @(posedge i_clk) begin
        if (wr_accept) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (wstrb[b]) begin
                    mem[wr_idx][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
        if (rd_accept) begin
            rdata <= mem[rd_idx];   // Read data registered on acceptance
        end
    end

    // Response valids
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_accept) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (rd_accept) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule : axi_lite_sram

// ==== hw/core_mem_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared sizes and types for the core memory port
// Address and data widths, access-size encoding,
// requestor count and SRAM depth
////////////////////////////////////////////////////////////

package core_mem_pkg;

    // Requestors, index 0 wins arbitration
    localparam int NUM_REQ   = 3;
    localparam int REQ_IDX_W = $clog2(NUM_REQ);   // 2 bits for three requestors

    // Bus widths
    localparam int PADDR_WIDTH = 32;
    localparam int WORD_WIDTH  = 32;
    localparam int STRB_WIDTH  = WORD_WIDTH / 8;  // One strobe per byte lane

    // SRAM geometry, address bits 9:2 pick the word
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    typedef logic [PADDR_WIDTH-1:0] paddr_t;
    typedef logic [WORD_WIDTH-1:0]  word_t;

    // Access size as issued by a requestor
    typedef enum logic [1:0] {
        SIZE_BYTE     = 2'b00,
        SIZE_HALFWORD = 2'b01,
        SIZE_WORD     = 2'b10
    } size_e;

endpackage : core_mem_pkg

// ==== hw/core_mem_top.sv ====
////////////////////////////////////////////////////////////
// Core memory port top level
// Arbiter, AXI4-Lite manager and SRAM subordinate
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_mem_top (
    input  logic                                               i_clk,
    input  logic                                               i_rst_n,
    input  logic                 [core_mem_pkg::NUM_REQ-1:0]   req_valid,
    input  logic                 [core_mem_pkg::NUM_REQ-1:0]   req_wen,
    input  core_mem_pkg::size_e  [core_mem_pkg::NUM_REQ-1:0]   req_size,
    input  core_mem_pkg::paddr_t [core_mem_pkg::NUM_REQ-1:0]   req_addr,
    input  core_mem_pkg::word_t  [core_mem_pkg::NUM_REQ-1:0]   req_wdata,
    output logic                 [core_mem_pkg::NUM_REQ-1:0]   req_ready,
    output core_mem_pkg::word_t                                req_rdata
);
    import core_mem_pkg::*;

    // Arbiter to manager
    logic   sel_valid;
    logic   sel_wen;
    size_e  sel_size;
    paddr_t sel_addr;
    word_t  sel_wdata;
    logic   sel_ready;
    word_t  sel_rdata;

    // AXI4-Lite between manager and SRAM
    logic                  awvalid, awready, wvalid, wready;
    logic                  bvalid, bready, arvalid, arready, rvalid, rready;
    paddr_t                awaddr, araddr;
    word_t                 wdata, rdata;
    logic [STRB_WIDTH-1:0] wstrb;
    logic [1:0]            bresp, rresp;

    mem_arbiter u_arbiter (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .req_valid (req_valid),
        .req_wen   (req_wen),
        .req_size  (req_size),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ready (req_ready),
        .req_rdata (req_rdata),
        .sel_valid (sel_valid),
        .sel_wen   (sel_wen),
        .sel_size  (sel_size),
        .sel_addr  (sel_addr),
        .sel_wdata (sel_wdata),
        .sel_ready (sel_ready),
        .sel_rdata (sel_rdata)
    );

    axi_lite_manager u_manager (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .sel_valid (sel_valid),
        .sel_wen   (sel_wen),
        .sel_size  (sel_size),
        .sel_addr  (sel_addr),
        .sel_wdata (sel_wdata),
        .sel_ready (sel_ready),
        .sel_rdata (sel_rdata),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .awprot    (),          // SRAM ignores protection
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .arprot    (),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp)
    );

    axi_lite_sram u_sram (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp)
    );

endmodule : core_mem_top

// ==== hw/mem_arbiter.sv ====
////////////////////////////////////////////////////////////
// Fixed-priority arbiter for the memory requestors
// Grant lock held until the access completes,
// request mux and ready demux
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_arbiter (
    input  logic                                               i_clk,
    input  logic                                               i_rst_n,
    // Requestor side
    input  logic                 [core_mem_pkg::NUM_REQ-1:0]   req_valid,
    input  logic                 [core_mem_pkg::NUM_REQ-1:0]   req_wen,
    input  core_mem_pkg::size_e  [core_mem_pkg::NUM_REQ-1:0]   req_size,
    input  core_mem_pkg::paddr_t [core_mem_pkg::NUM_REQ-1:0]   req_addr,
    input  core_mem_pkg::word_t  [core_mem_pkg::NUM_REQ-1:0]   req_wdata,
    output logic                 [core_mem_pkg::NUM_REQ-1:0]   req_ready,
    output core_mem_pkg::word_t                                req_rdata,
    // Selected request towards the AXI manager
    output logic                                               sel_valid,
    output logic                                               sel_wen,
    output core_mem_pkg::size_e                                sel_size,
    output core_mem_pkg::paddr_t                               sel_addr,
    output core_mem_pkg::word_t                                sel_wdata,
    input  logic                                               sel_ready,
    input  core_mem_pkg::word_t                                sel_rdata
);
    import core_mem_pkg::*;

    logic                 locked;      // An access is in flight
    logic [REQ_IDX_W-1:0] lock_idx;    // Owner of the in-flight access
    logic [REQ_IDX_W-1:0] prio_idx;    // Lowest-numbered valid requestor
    logic [REQ_IDX_W-1:0] grant_idx;

    // Priority pick, scan from the top so index 0 ends up winning
    always_comb begin
        prio_idx = '0;
        for (int i = NUM_REQ - 1; i >= 0; i--) begin
            if (req_valid[i]) begin
                prio_idx = REQ_IDX_W'(i);
            end
        end
    end

    assign grant_idx = locked ? lock_idx : prio_idx; // Owner keeps the port until done

    // Request mux
    assign sel_valid = req_valid[grant_idx];
    assign sel_wen   = req_wen[grant_idx];
    assign sel_size  = req_size[grant_idx];
    assign sel_addr  = req_addr[grant_idx];
    assign sel_wdata = req_wdata[grant_idx];

    // Completion goes back to the owner only
    always_comb begin
        req_ready            = '0;
        req_ready[grant_idx] = sel_ready;
    end

    assign req_rdata = sel_rdata;   // Shared, qualified by each requestor's ready

    // Lock taken on the first cycle of an access, dropped on completion
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            locked   <= 1'b0;
            lock_idx <= '0;
        end else if (sel_ready) begin
            locked   <= 1'b0;
        end else if (!locked && sel_valid) begin
            locked   <= 1'b1;
            lock_idx <= prio_idx;
        end
    end

endmodule : mem_arbiter

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the core memory port testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

TOP=core_mem_tb
LOG=sim.log

if ! verilator --binary --timing --top-module "$TOP" -f core_mem.f -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

// ==== verif/core_mem_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the core memory port
// Directed tests, reference memory model, value checker
// and a monitor on the ready outputs
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_mem_tb;
    import core_mem_pkg::*;

    logic                 i_clk;
    logic                 i_rst_n;
    logic   [NUM_REQ-1:0] req_valid;
    logic   [NUM_REQ-1:0] req_wen;
    size_e  [NUM_REQ-1:0] req_size;
    paddr_t [NUM_REQ-1:0] req_addr;
    word_t  [NUM_REQ-1:0] req_wdata;
    logic   [NUM_REQ-1:0] req_ready;
    word_t                req_rdata;

    word_t  ref_mem [MEM_WORDS];   // Reference model of the SRAM
    time    done_time [NUM_REQ];   // Time of the last ready per requestor
    int     checks = 0;
    int     errors = 0;
    int     monitor_errors = 0;    // Protocol errors seen by the monitor
    integer seed;

    core_mem_top UUT (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .req_valid (req_valid),
        .req_wen   (req_wen),
        .req_size  (req_size),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ready (req_ready),
        .req_rdata (req_rdata)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    task automatic check_value(input string name, input word_t got, input word_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Error: time %0t, %s: got 0x%08h, expected 0x%08h",
                     $time, name, got, expected);
        end
    endtask

    // Lanes touched by an access of the given size
    function automatic int lane_count(size_e size);
        case (size)
            SIZE_BYTE:     return 1;
            SIZE_HALFWORD: return 2;
            default:       return 4;
        endcase
    endfunction

    function automatic int lane_start(paddr_t addr, size_e size);
        case (size)
            SIZE_BYTE:     return int'(addr[1:0]);
            SIZE_HALFWORD: return addr[1] ? 2 : 0;
            default:       return 0;
        endcase
    endfunction

    // Low bytes of the data land on the addressed lanes
    function automatic void model_write(paddr_t addr, size_e size, word_t data);
        int idx;
        int first;
        idx   = int'(addr[MEM_IDX_W+1:2]);   // Upper bits wrap
        first = lane_start(addr, size);
        for (int k = 0; k < lane_count(size); k++) begin
            ref_mem[idx][(first + k)*8 +: 8] = data[k*8 +: 8];
        end
    endfunction

    function automatic word_t model_read(paddr_t addr, size_e size);
        word_t word;
        word_t val;
        int    first;
        word  = ref_mem[int'(addr[MEM_IDX_W+1:2])];
        first = lane_start(addr, size);
        val   = '0;                            // Zero extension
        for (int k = 0; k < lane_count(size); k++) begin
            val[k*8 +: 8] = word[(first + k)*8 +: 8];
        end
        return val;
    endfunction

    function automatic word_t fill_word(int i);
        return {8'h5a, 8'(i), 8'(~i), 8'(i * 7)};
    endfunction

    // Starts on a falling edge and returns on the falling edge after the ready cycle
    task automatic issue_access(input int r, input logic wen, input size_e size,
                                input paddr_t addr, input word_t wdata,
                                input bit keep, input int exp_lat);
        int    cycles;
        bit    got;
        word_t rd;
        req_valid[r] = 1'b1;
        req_wen[r]   = wen;
        req_size[r]  = size;
        req_addr[r]  = addr;
        req_wdata[r] = wdata;
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < 50) begin
            @(negedge i_clk);
            #1;                                // Inputs driven on this edge have settled
            cycles++;
            got = req_ready[r];
        end
        if (!got) begin
            errors++;
            $display("Timeout: requestor %0d saw no ready within %0d cycles", r, cycles);
        end else begin
            done_time[r] = $time;
            rd = req_rdata;                    // Valid only in the ready cycle
            if (wen) begin
                model_write(addr, size, wdata);
            end else begin
                check_value($sformatf("req_rdata (requestor %0d)", r), rd,
                            model_read(addr, size));
            end
            if (exp_lat != 0) begin
                check_value($sformatf("req_ready[%0d] latency", r), cycles, exp_lat);
            end
        end
        @(negedge i_clk);
        if (got) begin
            check_value($sformatf("req_ready[%0d] after pulse", r), 32'(req_ready[r]), '0);
        end
        if (!keep) begin
            req_valid[r] = 1'b0;
        end
    endtask

    task automatic word_write_read();
        check_value("req_ready", 32'(req_ready), '0);  // Idle after reset
        issue_access(0, 1'b1, SIZE_WORD, 32'h0000_0040, 32'hcafe_f00d, 1'b0, 1);
        issue_access(0, 1'b0, SIZE_WORD, 32'h0000_0040, '0, 1'b0, 1);
    endtask

    task automatic sub_word_merge();
        paddr_t base;
        base = 32'h0000_0080;
        issue_access(1, 1'b1, SIZE_WORD, base, 32'h0000_0000, 1'b0, 1);
        for (int off = 0; off < 4; off++) begin
            // Upper bytes of wdata must not reach memory
            issue_access(1, 1'b1, SIZE_BYTE, base + paddr_t'(off), 32'hdead_be10 + off, 1'b0, 1);
            issue_access(1, 1'b0, SIZE_WORD, base, '0, 1'b0, 1);
        end
        issue_access(1, 1'b1, SIZE_WORD, base + 4, 32'hffff_ffff, 1'b0, 1);
        for (int off = 0; off < 4; off += 2) begin
            issue_access(1, 1'b1, SIZE_HALFWORD, base + 4 + paddr_t'(off),
                         32'hbeef_1357 + off, 1'b0, 1);
            issue_access(1, 1'b0, SIZE_WORD, base + 4, '0, 1'b0, 1);
        end
        for (int off = 0; off < 8; off++) begin
            issue_access(1, 1'b0, SIZE_BYTE, base + paddr_t'(off), '0, 1'b0, 1);
        end
        for (int off = 0; off < 8; off += 2) begin
            issue_access(1, 1'b0, SIZE_HALFWORD, base + paddr_t'(off), '0, 1'b0, 1);
        end
    endtask

    task automatic priority_order();
        issue_access(1, 1'b1, SIZE_WORD, 32'h0000_0100, 32'h0bad_cafe, 1'b0, 1);
        for (int i = 0; i < NUM_REQ; i++) begin
            done_time[i] = 0;
        end
        fork
            issue_access(0, 1'b1, SIZE_WORD, 32'h0000_0104, 32'h1111_2222, 1'b0, 1);
            // Starts the cycle after requestor 0 is done
            issue_access(2, 1'b0, SIZE_WORD, 32'h0000_0100, '0, 1'b0, 3);
        join
        check_value("requestor 0 done before requestor 2",
                    32'(done_time[0] < done_time[2]), 1);
        issue_access(2, 1'b0, SIZE_WORD, 32'h0000_0104, '0, 1'b0, 1);
    endtask

    task automatic grant_lock();
        for (int i = 0; i < NUM_REQ; i++) begin
            done_time[i] = 0;
        end
        fork
            issue_access(1, 1'b0, SIZE_HALFWORD, 32'h0000_0102, '0, 1'b0, 1);
            begin
                @(negedge i_clk);              // Raised while requestor 1 owns the port
                issue_access(0, 1'b1, SIZE_BYTE, 32'h0000_0107, 32'h0000_0077, 1'b0, 2);
            end
        join
        check_value("requestor 1 done before requestor 0",
                    32'(done_time[1] < done_time[0]), 1);
        issue_access(0, 1'b0, SIZE_WORD, 32'h0000_0104, '0, 1'b0, 1);
    endtask

    task automatic random_mix();
        word_t  rnd;
        word_t  data;
        paddr_t addr;
        int     r;
        size_e  size;
        logic   wen;
        // Every word written first with valid held high
        for (int i = 0; i < MEM_WORDS; i++) begin
            issue_access(0, 1'b1, SIZE_WORD, paddr_t'(i * 4), fill_word(i),
                         i != MEM_WORDS - 1, 1);
        end
        for (int n = 0; n < 64; n++) begin
            rnd = $random(seed);
            r   = int'(rnd[7:0] % 8'd3);
            wen = rnd[8];
            case (rnd[10:9])
                2'b00:   size = SIZE_BYTE;
                2'b01:   size = SIZE_HALFWORD;
                default: size = SIZE_WORD;
            endcase
            addr = $random(seed);              // High bits exercise the wrap
            if (size == SIZE_HALFWORD) begin
                addr[0] = 1'b0;
            end else if (size == SIZE_WORD) begin
                addr[1:0] = 2'b00;
            end
            data = $random(seed);
            issue_access(r, wen, size, addr, data, 1'b0, 1);
        end
    endtask

    task automatic back_to_back();
        // Requestor 2 keeps valid up so each access follows the previous ready
        issue_access(2, 1'b1, SIZE_WORD,     32'h0000_0300, 32'h8765_4321, 1'b1, 1);
        issue_access(2, 1'b1, SIZE_BYTE,     32'h0000_0301, 32'h0000_00a5, 1'b1, 1);
        issue_access(2, 1'b0, SIZE_WORD,     32'h0000_0300, '0,            1'b1, 1);
        issue_access(2, 1'b1, SIZE_HALFWORD, 32'h0000_0302, 32'h0000_c3d2, 1'b1, 1);
        issue_access(2, 1'b0, SIZE_HALFWORD, 32'h0000_0302, '0,            1'b1, 1);
        issue_access(2, 1'b0, SIZE_BYTE,     32'h0000_0301, '0,            1'b1, 1);
        issue_access(2, 1'b0, SIZE_WORD,     32'h0000_0300, '0,            1'b0, 1);
    endtask

    // Ready must go to one requestor only, and only while it is valid
    always @(posedge i_clk) begin
        #2;
        if (i_rst_n) begin
            for (int i = 0; i < NUM_REQ; i++) begin
                if (req_ready[i] && !req_valid[i]) begin
                    monitor_errors++;
                    $display("Time %0t: requestor %0d got ready while its valid was low",
                             $time, i);
                end
            end
            if ($countones(req_ready) > 1) begin
                monitor_errors++;
                $display("Time %0t: more than one requestor got ready", $time);
            end
        end
    end

    initial begin
        seed      = 32'h94a5;
        i_rst_n   = 1'b0;
        req_valid = '0;
        req_wen   = '0;
        req_addr  = '0;
        req_wdata = '0;
        for (int i = 0; i < NUM_REQ; i++) begin
            req_size[i]  = SIZE_WORD;
            done_time[i] = 0;
        end
        repeat (4) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);

        word_write_read();
        sub_word_merge();
        priority_order();
        grant_lock();
        random_mix();
        back_to_back();

        repeat (2) @(negedge i_clk);
        $display("Checks: %0d, errors: %0d", checks, errors + monitor_errors);
        if (errors + monitor_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : core_mem_tb
